//--- cfu_store_pkg.sv
// instruction store types
`default_nettype none

package cfu_store_pkg;

  //////////////////////////////////////////////////
  // instruction memory geometry
  //////////////////////////////////////////////////

  // 512 locations max, one 32-bit instruction each
  localparam int INSTR_AWIDTH = 9;
  localparam int INSTR_DWIDTH = 32;

  typedef logic [INSTR_AWIDTH-1:0] instr_addr_t;
  typedef logic [INSTR_DWIDTH-1:0] instr_word_t;

  // inclusive program window walked by the sequencer
  typedef struct packed {
    instr_addr_t start_addr;
    instr_addr_t end_addr;
  } prog_range_t;

  // one micro-instruction beat, tagged with its store address
  typedef struct packed {
    instr_addr_t addr;
    instr_word_t word;
  } exec_beat_t;

endpackage

`default_nettype wire

//--- cfu_cmd_pkg.sv
// custom function unit command encoding
`default_nettype none

package cfu_cmd_pkg;

  // exec_req_t carries a program range
  import cfu_store_pkg::*;

  //////////////////////////////////////////////////
  // opcodes and sub-ops
  //////////////////////////////////////////////////

  // low 3 bits of the function id
  typedef enum logic [2:0] {
    op_byte_sum    = 3'd0,
    op_write_instr = 3'd3,
    op_read_instr  = 3'd4,
    op_exec        = 3'd7
  } cfu_op_e;

  // funct7 field when op is op_exec
  typedef enum logic [6:0] {
    exec_start     = 7'd0,
    exec_check     = 7'd1,
    exec_set_range = 7'd2
  } exec_sub_e;

  // funct7 under op_byte_sum that asks for the soft reset
  localparam logic [6:0] SOFT_RESET_SUB = 7'd1;

  // acknowledge word for commands with nothing to return
  localparam logic [31:0] RSP_ACK = 32'hffff_ffff;

  // accepted command, 74 bits
  typedef struct packed {
    logic [6:0]  funct7;
    cfu_op_e     op;
    logic [31:0] in0;
    logic [31:0] in1;
  } cfu_cmd_t;

  typedef enum logic [1:0] {
    idle,
    reply,
    wait_ram
  } rsp_state_e;

  // one-cycle strobes toward the control block
  typedef struct packed {
    logic        start;
    logic        set_range;
    logic        soft_reset_set;
    logic        cmd_taken;
    prog_range_t range;
  } exec_req_t;

endpackage

`default_nettype wire

//--- instr_ram.sv
// dual-port instruction memory
`timescale 1ns/1ps
`default_nettype none

module instr_ram
  import cfu_store_pkg::*;
#(
  parameter int INSTR_WORDS = 512
) (
  input  logic        clk,
  // port a, cpu side, read/write
  input  instr_addr_t a_addr,
  input  logic        a_we,
  input  instr_word_t a_wdata,
  output instr_word_t a_rdata,
  // port b, sequencer side, read only
  input  instr_addr_t b_addr,
  output instr_word_t b_rdata
);

  instr_word_t mem [INSTR_WORDS];

  // port a
  // read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    a_rdata <= mem[a_addr];
  end

  // port b
  // one cycle read latency, new address every cycle
  always_ff @(posedge clk) begin
    b_rdata <= mem[b_addr];
  end

endmodule

`default_nettype wire

//--- cfu_cmd_fsm.sv
// command decode and response FSM
`timescale 1ns/1ps
`default_nettype none

module cfu_cmd_fsm
  import cfu_cmd_pkg::*;
  import cfu_store_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  // host command side
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  // host response side, no back-pressure
  output logic        rsp_valid,
  output logic [31:0] rsp_outputs_0,
  // instruction ram port a
  output instr_addr_t ram_addr,
  output logic        ram_we,
  output instr_word_t ram_wdata,
  input  instr_word_t ram_rdata,
  // control block
  output exec_req_t   exec_req,
  input  logic        done
);

  rsp_state_e  state_q;
  cfu_cmd_t    cmd_q;
  logic        cmd_take;
  // high in the cycle right after a command is taken
  logic        taken_q;
  logic [8:0]  byte_sum;
  logic [31:0] rsp_word;
  exec_sub_e   sub_op;

  // ready whenever no command is in flight
  assign cmd_ready = (state_q == idle);
  assign cmd_take  = cmd_valid & cmd_ready;

  //////////////////////////////////////////////////
  // command capture
  //////////////////////////////////////////////////

  // payload, loaded only on a taken command
  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cmd_q.funct7 <= cmd_function_id[9:3];
      cmd_q.op     <= cfu_op_e'(cmd_function_id[2:0]);
      cmd_q.in0    <= cmd_inputs_0;
      cmd_q.in1    <= cmd_inputs_1;
    end
  end

  assign sub_op = exec_sub_e'(cmd_q.funct7);

  //////////////////////////////////////////////////
  // response sequencing
  //////////////////////////////////////////////////

  // ram reads take the extra wait_ram step, all else replies next cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q   <= idle;
      taken_q   <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      taken_q   <= cmd_take;
      rsp_valid <= 1'b0;
      case (state_q)
        idle: begin
          if (cmd_take) begin
            if (cmd_function_id[2:0] == op_read_instr) begin
              state_q <= wait_ram;
            end else begin
              state_q <= reply;
            end
          end
        end
        // ram samples the address at the end of this cycle
        wait_ram: state_q <= reply;
        reply: begin
          rsp_valid <= 1'b1;
          state_q   <= idle;
        end
        default: state_q <= idle;
      endcase
    end
  end

  // response word held until the next reply
  always_ff @(posedge clk) begin
    if (state_q == reply) begin
      rsp_outputs_0 <= rsp_word;
    end
  end

  assign byte_sum = {1'b0, cmd_q.in0[7:0]} + {1'b0, cmd_q.in1[7:0]};

  // result select, dropped ops answer zero
  always_comb begin
    rsp_word = '0;
    case (cmd_q.op)
      op_byte_sum:    rsp_word = {23'd0, byte_sum};
      op_write_instr: rsp_word = RSP_ACK;
      op_read_instr:  rsp_word = ram_rdata;
      op_exec: begin
        case (sub_op)
          exec_start:     rsp_word = RSP_ACK;
          exec_set_range: rsp_word = RSP_ACK;
          exec_check:     rsp_word = {31'd0, done};
          default:        rsp_word = '0;
        endcase
      end
      default: rsp_word = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // side effects, one cycle after the command
  //////////////////////////////////////////////////

  // cpu port of the store, in0 is the address and in1 the data
  assign ram_addr  = cmd_q.in0[INSTR_AWIDTH-1:0];
  assign ram_wdata = cmd_q.in1;
  assign ram_we    = taken_q & (cmd_q.op == op_write_instr);

  // strobes for the control block
  always_comb begin
    exec_req.cmd_taken      = taken_q;
    exec_req.start          = taken_q & (cmd_q.op == op_exec) & (sub_op == exec_start);
    exec_req.set_range      = taken_q & (cmd_q.op == op_exec) & (sub_op == exec_set_range);
    exec_req.soft_reset_set = taken_q & (cmd_q.op == op_byte_sum)
                              & (cmd_q.funct7 == SOFT_RESET_SUB);
    // range: start in in0, end in in1
    exec_req.range.start_addr = cmd_q.in0[INSTR_AWIDTH-1:0];
    exec_req.range.end_addr   = cmd_q.in1[INSTR_AWIDTH-1:0];
  end

endmodule

`default_nettype wire

//--- cfu_exec_regs.sv
// execution control registers
`timescale 1ns/1ps
`default_nettype none

module cfu_exec_regs
  import cfu_cmd_pkg::*;
  import cfu_store_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  exec_req_t   exec_req,
  input  logic        finished,
  output logic        done,
  output logic        run,
  output logic        seq_resetn,
  output prog_range_t range
);

  logic soft_hold_q;
  logic busy_q;
  logic done_q;
  logic start_ok;

  // a start during an active run is dropped
  assign start_ok = exec_req.start & ~busy_q;

  //////////////////////////////////////////////////
  // soft reset level
  //////////////////////////////////////////////////

  // held until the next command that is not a soft reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      soft_hold_q <= 1'b0;
    end else if (exec_req.soft_reset_set) begin
      soft_hold_q <= 1'b1;
    end else if (exec_req.cmd_taken) begin
      soft_hold_q <= 1'b0;
    end
  end

  // sequencer sees both the port reset and the soft reset
  assign seq_resetn = resetn & ~soft_hold_q;

  //////////////////////////////////////////////////
  // program range and run control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      range <= '0;
    end else if (exec_req.set_range) begin
      range <= exec_req.range;
    end
  end

  // run is a single pulse, busy spans start to finished
  always_ff @(posedge clk) begin
    if (!resetn) begin
      run    <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      run <= start_ok;
      if (exec_req.soft_reset_set) begin
        busy_q <= 1'b0;
      end else if (start_ok) begin
        busy_q <= 1'b1;
      end else if (finished) begin
        busy_q <= 1'b0;
      end
    end
  end

  // sticky done, a fresh start or a soft reset clears it
  always_ff @(posedge clk) begin
    if (!resetn) begin
      done_q <= 1'b0;
    end else if (exec_req.soft_reset_set || start_ok) begin
      done_q <= 1'b0;
    end else if (finished) begin
      done_q <= 1'b1;
    end
  end

  // finished shows through so a check right after the last beat sees it
  assign done = done_q | finished;

endmodule

`default_nettype wire

//--- instr_sequencer.sv
// instruction fetch sequencer
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer
  import cfu_store_pkg::*;
(
  input  logic        clk,
  input  logic        seq_resetn,
  input  logic        run,
  input  prog_range_t range,
  // instruction ram port b
  output instr_addr_t b_addr,
  input  instr_word_t b_rdata,
  // micro-instruction stream
  output logic        exec_valid,
  output exec_beat_t  exec_beat,
  output logic        finished
);

  typedef enum logic [1:0] {
    idle,
    fetch,
    drain
  } seq_state_e;

  seq_state_e  state_q;
  instr_addr_t last_addr_q;
  // read issued last cycle, word on b_rdata now
  logic        rd_valid_q;
  instr_addr_t rd_addr_q;

  //////////////////////////////////////////////////
  // fetch FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!seq_resetn) begin
      state_q    <= idle;
      rd_valid_q <= 1'b0;
      exec_valid <= 1'b0;
      finished   <= 1'b0;
    end else begin
      rd_valid_q <= (state_q == fetch);
      exec_valid <= rd_valid_q;
      finished   <= 1'b0;
      case (state_q)
        idle: begin
          if (run) begin
            state_q <= fetch;
          end
        end
        // one address per cycle up to the last one
        fetch: begin
          if (b_addr == last_addr_q) begin
            state_q <= drain;
          end
        end
        // pipeline empty once the final beat is on the output
        drain: begin
          if (exec_valid && !rd_valid_q) begin
            finished <= 1'b1;
            state_q  <= idle;
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // address and beat datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state_q == idle && run) begin
      b_addr <= range.start_addr;
      // reversed range collapses to the start address
      if (range.end_addr < range.start_addr) begin
        last_addr_q <= range.start_addr;
      end else begin
        last_addr_q <= range.end_addr;
      end
    end else if (state_q == fetch && b_addr != last_addr_q) begin
      b_addr <= b_addr + 1'b1;
    end
    // address follows its word through the ram latency
    rd_addr_q <= b_addr;
    exec_beat.addr <= rd_addr_q;
    exec_beat.word <= b_rdata;
  end

endmodule

`default_nettype wire

//--- cfu_top.sv
// compute unit command front end
`timescale 1ns/1ps
`default_nettype none

module cfu_top
  import cfu_cmd_pkg::*;
  import cfu_store_pkg::*;
#(
  parameter int INSTR_WORDS = 512
) (
  input  logic        clk,
  input  logic        resetn,
  // host command and response
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  output logic        rsp_valid,
  output logic [31:0] rsp_outputs_0,
  // micro-instruction stream out
  output logic        exec_valid,
  output exec_beat_t  exec_beat
);

  // cpu port of the store
  instr_addr_t ram_a_addr;
  logic        ram_a_we;
  instr_word_t ram_a_wdata;
  instr_word_t ram_a_rdata;

  // sequencer port of the store
  instr_addr_t ram_b_addr;
  instr_word_t ram_b_rdata;

  // control paths
  exec_req_t   exec_req;
  logic        done;
  logic        run;
  logic        seq_resetn;
  logic        finished;
  prog_range_t range;

  cfu_cmd_fsm u_cmd_fsm (
    .clk             (clk),
    .resetn          (resetn),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_outputs_0   (rsp_outputs_0),
    .ram_addr        (ram_a_addr),
    .ram_we          (ram_a_we),
    .ram_wdata       (ram_a_wdata),
    .ram_rdata       (ram_a_rdata),
    .exec_req        (exec_req),
    .done            (done)
  );

  cfu_exec_regs u_exec_regs (
    .clk        (clk),
    .resetn     (resetn),
    .exec_req   (exec_req),
    .finished   (finished),
    .done       (done),
    .run        (run),
    .seq_resetn (seq_resetn),
    .range      (range)
  );

  instr_ram #(
    .INSTR_WORDS (INSTR_WORDS)
  ) u_instr_ram (
    .clk     (clk),
    .a_addr  (ram_a_addr),
    .a_we    (ram_a_we),
    .a_wdata (ram_a_wdata),
    .a_rdata (ram_a_rdata),
    .b_addr  (ram_b_addr),
    .b_rdata (ram_b_rdata)
  );

  instr_sequencer u_sequencer (
    .clk        (clk),
    .seq_resetn (seq_resetn),
    .run        (run),
    .range      (range),
    .b_addr     (ram_b_addr),
    .b_rdata    (ram_b_rdata),
    .exec_valid (exec_valid),
    .exec_beat  (exec_beat),
    .finished   (finished)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic resetn
);

  // free running clock, low at time zero
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // reset held for a fixed number of rising edges
  // released on a falling edge, away from the sampling edge
  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_cfu.sv
// command front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cfu
  import cfu_cmd_pkg::*;
  import cfu_store_pkg::*;
();

  localparam int CLK_PERIOD_NS   = 10;
  localparam int RESET_CYCLES    = 5;
  localparam int MEM_WORDS       = 512;
  localparam int SUM_TRIALS      = 20;
  localparam int STORE_WRITES    = 32;
  localparam int BLOCK_BASE      = 200;
  localparam int BLOCK_LEN       = 16;
  localparam int RSP_WAIT_LIMIT  = 16;
  localparam int BEAT_WAIT_LIMIT = 64;
  // about 120 commands of well under 10 cycles each plus slack for the runs
  localparam int CMD_ESTIMATE    = 150;
  localparam int CYCLES_PER_CMD  = 10;
  localparam int WATCHDOG_NS     = (CMD_ESTIMATE * CYCLES_PER_CMD + 500) * CLK_PERIOD_NS;
  // ops without a function in this unit
  localparam logic [11:0] DROPPED_OPS = {3'd1, 3'd2, 3'd5, 3'd6};
  localparam logic [31:0] ACK_WORD    = 32'hffff_ffff;

  logic        clk;
  logic        resetn;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_function_id;
  logic [31:0] cmd_inputs_0;
  logic [31:0] cmd_inputs_1;
  logic        rsp_valid;
  logic [31:0] rsp_outputs_0;
  logic        exec_valid;
  exec_beat_t  exec_beat;

  // mirror of every store write
  instr_word_t model_mem [MEM_WORDS];
  instr_addr_t wr_addr [STORE_WRITES];
  exec_beat_t  beat_q [$];
  logic [31:0] lcg_state;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clk    (clk),
    .resetn (resetn)
  );

  cfu_top #(
    .INSTR_WORDS (MEM_WORDS)
  ) u_cfu_top (
    .clk             (clk),
    .resetn          (resetn),
    .cmd_valid       (cmd_valid),
    .cmd_ready       (cmd_ready),
    .cmd_function_id (cmd_function_id),
    .cmd_inputs_0    (cmd_inputs_0),
    .cmd_inputs_1    (cmd_inputs_1),
    .rsp_valid       (rsp_valid),
    .rsp_outputs_0   (rsp_outputs_0),
    .exec_valid      (exec_valid),
    .exec_beat       (exec_beat)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val)
    else stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                     name, exp_val, act_val));
  endtask

  // lcg with halves swapped so the low bits are usable
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // funct7 on top and op in the low 3 bits
  function automatic logic [9:0] make_fid(input logic [6:0] funct7, input logic [2:0] op);
    return {funct7, op};
  endfunction

  // entered just after a falling edge and returns on the one that shows rsp_valid
  task automatic send_cmd(input logic [9:0] fid, input logic [31:0] in0,
                          input logic [31:0] in1, output logic [31:0] rsp,
                          output int latency);
    int waited;
    waited = 0;
    while (!cmd_ready) begin
      if (waited >= RSP_WAIT_LIMIT) begin
        stop_with_failure("cmd_ready stayed low, the command could not be sent");
      end
      @(negedge clk);
      waited++;
    end
    cmd_valid       = 1'b1;
    cmd_function_id = fid;
    cmd_inputs_0    = in0;
    cmd_inputs_1    = in1;
    // this edge takes the command
    @(posedge clk);
    latency = 1;
    @(negedge clk);
    cmd_valid = 1'b0;
    while (!rsp_valid) begin
      if (latency >= RSP_WAIT_LIMIT) begin
        stop_with_failure("no response arrived for a taken command");
      end
      @(posedge clk);
      latency++;
      @(negedge clk);
    end
    rsp = rsp_outputs_0;
  endtask

  task automatic expect_rsp(input string name, input logic [9:0] fid,
                            input logic [31:0] in0, input logic [31:0] in1,
                            input logic [31:0] exp_word, input int exp_latency);
    logic [31:0] rsp;
    int          latency;
    send_cmd(fid, in0, in1, rsp, latency);
    check_equal(name, exp_word, rsp);
    check_equal($sformatf("%s latency", name), 32'(exp_latency), 32'(latency));
  endtask

  task automatic write_word(input string name, input instr_addr_t addr,
                            input instr_word_t data);
    expect_rsp(name, make_fid(7'd0, op_write_instr), 32'(addr), data, ACK_WORD, 2);
    model_mem[addr] = data;
  endtask

  // start the stored range and compare every beat with the model
  task automatic run_and_verify(input string name, input instr_addr_t first,
                                input instr_addr_t last);
    int          expected_beats;
    int          waited;
    exec_beat_t  beat;
    instr_addr_t addr;
    // a reversed range issues only its start
    if (last < first) begin
      expected_beats = 1;
    end else begin
      expected_beats = int'(last) - int'(first) + 1;
    end
    beat_q.delete();
    expect_rsp($sformatf("%s start", name), make_fid(exec_start, op_exec), 0, 0, ACK_WORD, 2);
    // an accepted start clears done long before the last beat
    expect_rsp($sformatf("%s done cleared", name), make_fid(exec_check, op_exec), 0, 0,
               32'd0, 2);
    // queue is filled on falling edges and read on rising ones
    waited = 0;
    while (beat_q.size() < expected_beats) begin
      if (waited >= BEAT_WAIT_LIMIT) begin
        stop_with_failure($sformatf("%s: exec beats stopped arriving", name));
      end
      @(posedge clk);
      waited++;
    end
    // room for a stray extra beat to show up
    repeat (4) @(posedge clk);
    check_equal($sformatf("%s beat count", name), 32'(expected_beats), 32'(beat_q.size()));
    addr = first;
    foreach (beat_q[i]) begin
      beat = beat_q[i];
      check_equal($sformatf("%s beat[%0d] addr", name, i), 32'(addr), 32'(beat.addr));
      check_equal($sformatf("%s beat[%0d] word", name, i), model_mem[addr], beat.word);
      addr = addr + 9'd1;
    end
    @(negedge clk);
    expect_rsp($sformatf("%s done", name), make_fid(exec_check, op_exec), 0, 0, 32'd1, 2);
  endtask

  //////////////////////////////////////////////////
  // monitors and watchdog
  //////////////////////////////////////////////////

  // beats are stable by the falling edge
  always @(negedge clk) begin
    if (exec_valid) begin
      beat_q.push_back(exec_beat);
    end
  end

  rsp_quiet_in_reset: assert property (@(posedge clk) !resetn |-> !$rose(rsp_valid))
  else stop_with_failure("rsp_valid rose while resetn was low");

  beat_quiet_in_reset: assert property (@(posedge clk) !resetn |-> !$rose(exec_valid))
  else stop_with_failure("exec_valid rose while resetn was low");

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("watchdog expired before the tests finished");
  end

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [2:0]  op;
    instr_addr_t addr;
    lcg_state       = 32'hd11e_b50d;
    // a start offered while reset is low must not be taken
    cmd_valid       = 1'b1;
    cmd_function_id = make_fid(exec_start, op_exec);
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    @(posedge resetn);
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    @(negedge clk);

    // reset state and byte sum
    check_equal("reset cmd_ready", 32'd1, 32'(cmd_ready));
    check_equal("reset rsp_valid", 32'd0, 32'(rsp_valid));
    check_equal("reset exec_valid", 32'd0, 32'(exec_valid));
    expect_rsp("check after reset", make_fid(exec_check, op_exec), 0, 0, 32'd0, 2);
    for (int i = 0; i < SUM_TRIALS; i++) begin
      a = next_random();
      b = next_random();
      expect_rsp($sformatf("byte_sum[%0d]", i), make_fid(7'd0, op_byte_sum), a, b,
                 32'(a[7:0]) + 32'(b[7:0]), 2);
    end

    // dropped ops answer zero
    for (int i = 0; i < 4; i++) begin
      op = DROPPED_OPS[(3 - i) * 3 +: 3];
      r  = next_random();
      a  = next_random();
      b  = next_random();
      expect_rsp($sformatf("dropped op %0d", op), make_fid(r[6:0], op), a, b, 32'd0, 2);
    end

    // instruction store write and read back
    for (int i = 0; i < STORE_WRITES; i++) begin
      r          = next_random();
      addr       = r[INSTR_AWIDTH-1:0];
      wr_addr[i] = addr;
      write_word($sformatf("store write[%0d]", i), addr, next_random());
    end
    for (int i = 0; i < STORE_WRITES; i++) begin
      expect_rsp($sformatf("store read[%0d]", i), make_fid(7'd0, op_read_instr),
                 32'(wr_addr[i]), 0, model_mem[wr_addr[i]], 3);
    end

    // program run over a freshly written block
    for (int i = 0; i < BLOCK_LEN; i++) begin
      write_word($sformatf("block write[%0d]", i), instr_addr_t'(BLOCK_BASE + i),
                 next_random());
    end
    expect_rsp("set block range", make_fid(exec_set_range, op_exec), BLOCK_BASE,
               BLOCK_BASE + BLOCK_LEN - 1, ACK_WORD, 2);
    run_and_verify("block run", instr_addr_t'(BLOCK_BASE),
                   instr_addr_t'(BLOCK_BASE + BLOCK_LEN - 1));

    // soft reset drops done while the range survives
    a = next_random();
    b = next_random();
    expect_rsp("soft reset", make_fid(7'd1, op_byte_sum), a, b,
               32'(a[7:0]) + 32'(b[7:0]), 2);
    expect_rsp("check after soft reset", make_fid(exec_check, op_exec), 0, 0, 32'd0, 2);
    run_and_verify("block rerun", instr_addr_t'(BLOCK_BASE),
                   instr_addr_t'(BLOCK_BASE + BLOCK_LEN - 1));

    // end below start
    expect_rsp("set reversed range", make_fid(exec_set_range, op_exec), BLOCK_BASE + 12,
               BLOCK_BASE + 4, ACK_WORD, 2);
    run_and_verify("reversed run", instr_addr_t'(BLOCK_BASE + 12),
                   instr_addr_t'(BLOCK_BASE + 4));

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
cfu_store_pkg.sv
cfu_cmd_pkg.sv
instr_ram.sv
cfu_cmd_fsm.sv
cfu_exec_regs.sv
instr_sequencer.sv
cfu_top.sv
tb_clock_gen.sv
tb_cfu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the command front end testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_cfu

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cfu -f build.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi
